//--- Makefile
VERILATOR  ?= verilator
FLIST      ?= flist.f
TB_TOP     ?= tb_ca_display
RTL_TOP    ?= ca_display_top
OBJ_DIR    ?= obj_dir
TIMESCALE  ?= --timescale 1ns/1ps
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing
RTL_SRCS   ?= $(filter verilog/%,$(shell cat $(FLIST)))
PASS_MSG   := Result: PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(TIMESCALE) --top-module $(RTL_TOP) $(RTL_SRCS)

build:
	$(VERILATOR) $(SIM_FLAGS) $(TIMESCALE) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: build
	@out="$$($(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
+incdir+testbench
verilog/ca_pkg.sv
verilog/ca_next_row.sv
verilog/ca_seed_lfsr.sv
verilog/ca_row_store.sv
verilog/ca_scan_ctrl.sv
verilog/ca_display_top.sv
testbench/tb_ca_display.sv

//--- testbench/ca_model.svh
//////////////////////////////////////////////////////////////////////
// Automaton reference model
// Seed rows, neighbourhood rule lookup and the LFSR word step
//////////////////////////////////////////////////////////////////////
`ifndef CA_MODEL_SVH
`define CA_MODEL_SVH

logic [ROW_WIDTH-1:0] model_row;                 // Row being drawn
logic [31:0]          model_lfsr [WORDS];        // One word per 32 cells

// Cell i looks at cells i-1, i and i+1, dead beyond the edges
function automatic logic [ROW_WIDTH-1:0] evolve_row(input logic [ROW_WIDTH-1:0] r,
                                                    input logic [7:0]           rule);
   logic [ROW_WIDTH-1:0] left;
   logic [ROW_WIDTH-1:0] right;
   logic [ROW_WIDTH-1:0] n;
   left  = r << 1;                               // left[i] is cell i-1
   right = r >> 1;                               // right[i] is cell i+1
   for (int i = 0; i < ROW_WIDTH; i++)
      n[i] = rule[{left[i], r[i], right[i]}];
   return n;
endfunction

// Shift left, feedback from bits 31, 21, 1 and 0
function automatic logic [31:0] lfsr_next(input logic [31:0] w);
   return {w[30:0], w[31] ^ w[21] ^ w[1] ^ w[0]};
endfunction

function automatic logic [ROW_WIDTH-1:0] lfsr_row();
   logic [ROW_WIDTH-1:0] r;
   for (int k = 0; k < WORDS; k++)
      r[32*k +: 32] = model_lfsr[k];             // Word k covers cells 32k up
   return r;
endfunction

task automatic model_reset(input bit use_random);
   for (int k = 0; k < WORDS; k++)
      model_lfsr[k] = ca_pkg::LFSR_SEEDS[k];
   model_row = '0;
   if (use_random)
      model_row = lfsr_row();
   else
      model_row[ROW_WIDTH/2] = 1'b1;             // Single dot in the middle
endtask

// Random mode restart, one step per word
task automatic model_reseed();
   for (int k = 0; k < WORDS; k++)
      model_lfsr[k] = lfsr_next(model_lfsr[k]);
   model_row = lfsr_row();
endtask

`endif

//--- testbench/tb_ca_display.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Testbench for the cellular automaton frame generator
// Random rules and seed modes, restarts and a mid-frame reset, with
// every pixel write checked against a model
//////////////////////////////////////////////////////////////////////

module tb_ca_display;

   localparam int ROW_WIDTH      = 64;
   localparam int ROW_COUNT      = 12;
   localparam int WORDS          = ROW_WIDTH / 32;
   localparam int PIX_PER_FRAME  = ROW_WIDTH * ROW_COUNT;
   localparam int FRAMES         = 8;            // Cut frame counted in full
   localparam int TIMEOUT_CYCLES = 4 * FRAMES * PIX_PER_FRAME + 2000;

   logic                         SW;
   logic                         reset;
   logic [7:0]                   rule_sel;
   logic                         random_seed;
   logic                         restart;
   logic                         pix_we;
   logic [$clog2(ROW_WIDTH)-1:0] pix_x;
   logic [$clog2(ROW_COUNT)-1:0] pix_y;
   logic                         pix_bit;
   logic                         frame_done;
   ca_pkg::ca_state_e            ctrl_state;   // For the timeout message

   logic [31:0] rng_state = 32'he98c_946c;
   logic [7:0]  cfg_rule = '0;                 // Applied during reset
   bit          cfg_random = 1'b0;
   logic [7:0]  mon_rule;                      // Monitor copies
   bit          mon_random;
   string       test_name = "startup";
   logic        rst_seen = 1'b0;               // Reset at the last rising edge
   int          exp_x;
   int          exp_y;
   int          wcount;
   bit          prev_we;
   bit          prev_fd;
   bit          done_due;                      // Last write of a frame seen
   int          pix_checked = 0;
   int          frames = 0;
   int          pix_errors = 0;
   int          proto_errors = 0;
   int          restart_errors = 0;
   int          cycles = 0;

   `include "ca_model.svh"

   ca_display_top #(
      .ROW_WIDTH (ROW_WIDTH),
      .ROW_COUNT (ROW_COUNT)
   ) DUT (
      .SW          (SW),
      .reset       (reset),
      .rule_sel    (rule_sel),
      .random_seed (random_seed),
      .restart     (restart),
      .pix_we      (pix_we),
      .pix_x       (pix_x),
      .pix_y       (pix_y),
      .pix_bit     (pix_bit),
      .frame_done  (frame_done)
   );

   assign ctrl_state = DUT.u_scan_ctrl.state;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function automatic logic [7:0] random_byte();
      rng_state = xorshift32(rng_state);
      return rng_state[15:8];
   endfunction

   initial
   begin
      SW = 1'b0;
      forever #20 SW = ~SW;                    // 40 ns period
   end

   // Run limit from the total pixel count
   initial
   begin
      while (cycles < TIMEOUT_CYCLES)
      begin
         @(posedge SW);
         cycles++;
      end
      $display("Timeout after %0d cycles in %s, controller in %s",
               cycles, test_name, ctrl_state.name());
      $display("Result: FAILED");
      $finish;
   end

   always @(posedge SW)
   begin
      rst_seen <= reset;
   end

   //////////////////////////////////////////////////////////////////////
   // Write monitor, outputs sampled mid-cycle
   //////////////////////////////////////////////////////////////////////
   always @(negedge SW)
   begin
      if (rst_seen)
      begin
         if (pix_we || frame_done)
         begin
            $display("%s: write strobe or frame_done high in reset", test_name);
            proto_errors++;
         end
         mon_rule   = cfg_rule;                // Same sampling as the DUT
         mon_random = cfg_random;
         model_reset(cfg_random);
         exp_x      = 0;
         exp_y      = 0;
         wcount     = 0;
         done_due   = 1'b0;
         prev_we    = 1'b0;
         prev_fd    = 1'b0;
      end
      else
      begin
         if (done_due && !frame_done)
         begin
            $display("%s: frame_done did not rise after the last write", test_name);
            proto_errors++;
         end
         done_due = 1'b0;
         if (pix_we && (prev_we || frame_done))
         begin
            $display("%s: write back to back or while frame_done high", test_name);
            proto_errors++;
         end
         if (pix_we)
         begin
            if (int'(pix_x) != exp_x || int'(pix_y) != exp_y)
            begin
               $display("[ERROR] %s: address expected (%0d,%0d) actual (%0d,%0d)",
                        test_name, exp_x, exp_y, pix_x, pix_y);
               pix_errors++;
            end
            if (pix_bit !== model_row[exp_x])
            begin
               $display("[ERROR] %s: pixel (%0d,%0d) expected %b actual %b",
                        test_name, exp_x, exp_y, model_row[exp_x], pix_bit);
               pix_errors++;
            end
            pix_checked++;
            wcount++;
            if (exp_x == ROW_WIDTH - 1)
            begin
               model_row = evolve_row(model_row, mon_rule); // Also after last row
               exp_x     = 0;
               if (exp_y == ROW_COUNT - 1)
               begin
                  exp_y    = 0;
                  done_due = 1'b1;
                  if (mon_random)
                     model_reseed();
               end
               else
                  exp_y++;
            end
            else
               exp_x++;
         end
         if (frame_done && !prev_fd)
         begin
            frames++;
            if (wcount != PIX_PER_FRAME)
            begin
               $display("[ERROR] %s: writes per frame expected %0d actual %0d",
                        test_name, PIX_PER_FRAME, wcount);
               proto_errors++;
            end
            wcount = 0;
         end
         prev_we = pix_we;
         prev_fd = frame_done;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////////////////////////
   task automatic apply_reset(input logic [7:0] rule, input bit use_random);
      @(negedge SW);
      reset       = 1'b1;
      rule_sel    = rule;
      random_seed = use_random;
      cfg_rule    = rule;
      cfg_random  = use_random;
      repeat (16) @(negedge SW);
      reset       = 1'b0;
      rule_sel    = random_byte();             // Ignored outside reset
      random_seed = ~use_random;
   endtask

   task automatic wait_frame_done();
      @(negedge SW);
      while (!frame_done)
         @(negedge SW);
   endtask

   // Press, hold, release, then frame_done drops two cycles later
   task automatic press_restart();
      logic held;
      logic after_step;
      repeat (3) @(negedge SW);                // Controller settles in IDLE
      restart = 1'b1;
      repeat (4) @(negedge SW);
      held    = frame_done;
      restart = 1'b0;
      @(negedge SW);
      after_step = frame_done;
      @(negedge SW);
      if (held !== 1'b1 || after_step !== 1'b1 || frame_done !== 1'b0)
      begin
         $display("[ERROR] %s: frame_done around restart expected 110 actual %b%b%b",
                  test_name, held, after_step, frame_done);
         restart_errors++;
      end
   endtask

   initial
   begin
      logic [7:0] pick;
      reset       = 1'b1;
      rule_sel    = '0;
      random_seed = 1'b0;
      restart     = 1'b0;

      test_name = "dot_frame";
      apply_reset(random_byte(), 1'b0);
      wait_frame_done();
      test_name = "dot_restart";               // Continues from next generation
      press_restart();
      wait_frame_done();

      test_name = "random_frame";
      apply_reset(random_byte(), 1'b1);
      wait_frame_done();
      test_name = "random_restart";
      repeat (2)
      begin
         press_restart();
         wait_frame_done();
      end

      // Cut a frame about halfway with a new rule and mode
      test_name = "reset_mid_frame";
      press_restart();
      repeat (1000) @(negedge SW);
      pick = random_byte();
      apply_reset(random_byte(), pick[0]);
      wait_frame_done();
      press_restart();
      wait_frame_done();

      $display("Checked %0d writes in %0d frames, errors %0d pixel %0d protocol %0d restart",
               pix_checked, frames, pix_errors, proto_errors, restart_errors);
      if (pix_errors == 0 && proto_errors == 0 && restart_errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

//--- verilog/ca_display_top.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Cellular automaton frame generator
// Draws ROW_COUNT generations of a 1-D automaton as a stream of
// pixel writes for an external frame buffer
//////////////////////////////////////////////////////////////////////

module ca_display_top #(
   parameter int ROW_WIDTH = 640,            // Multiple of 32, max 640
   parameter int ROW_COUNT = 480
) (
   input  logic                         SW,
   input  logic                         reset,
   input  logic [ca_pkg::RULE_BITS-1:0] rule_sel,
   input  logic                         random_seed,
   input  logic                         restart,
   output logic                         pix_we,
   output logic [$clog2(ROW_WIDTH)-1:0] pix_x,
   output logic [$clog2(ROW_COUNT)-1:0] pix_y,
   output logic                         pix_bit,
   output logic                         frame_done
);

   // Row has to split evenly into LFSR words
   if ((ROW_WIDTH % ca_pkg::LFSR_BITS) != 0 ||
       ROW_WIDTH > ca_pkg::MAX_WORDS * ca_pkg::LFSR_BITS)
   begin : g_width_check
      $error("ROW_WIDTH %0d not supported", ROW_WIDTH);
   end

   logic [ROW_WIDTH-1:0]         cur_row;
   logic [ROW_WIDTH-1:0]         next_row;
   logic [ROW_WIDTH-1:0]         random_row;
   logic [ca_pkg::RULE_BITS-1:0] rule;
   logic                         seed_load;
   logic                         seed_step;
   logic                         row_step;

   // Counters double as the pixel address
   ca_scan_ctrl #(
      .ROW_WIDTH (ROW_WIDTH),
      .ROW_COUNT (ROW_COUNT)
   ) u_scan_ctrl (
      .SW         (SW),
      .reset      (reset),
      .restart    (restart),
      .col        (pix_x),
      .row        (pix_y),
      .pix_we     (pix_we),
      .seed_load  (seed_load),
      .seed_step  (seed_step),
      .row_step   (row_step),
      .frame_done (frame_done)
   );

   ca_row_store #(
      .ROW_WIDTH (ROW_WIDTH)
   ) u_row_store (
      .SW          (SW),
      .reset       (reset),
      .rule_sel    (rule_sel),
      .random_seed (random_seed),
      .seed_load   (seed_load),
      .row_step    (row_step),
      .col         (pix_x),
      .random_row  (random_row),
      .next_row    (next_row),
      .cur_row     (cur_row),
      .rule        (rule),
      .pix_bit     (pix_bit)
   );

   ca_next_row #(
      .ROW_WIDTH (ROW_WIDTH)
   ) u_next_row (
      .cur_row  (cur_row),
      .rule     (rule),
      .next_row (next_row)
   );

   ca_seed_lfsr #(
      .ROW_WIDTH (ROW_WIDTH)
   ) u_seed_lfsr (
      .SW         (SW),
      .reset      (reset),
      .seed_step  (seed_step),
      .random_row (random_row)
   );

endmodule

//--- verilog/ca_next_row.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Next generation of a one-dimensional cellular automaton
// Every cell looks up its 3-cell neighbourhood in the rule,
// cells beyond either end of the row read as dead
//////////////////////////////////////////////////////////////////////

module ca_next_row #(
   parameter int ROW_WIDTH = 640
) (
   input  logic [ROW_WIDTH-1:0]         cur_row,
   input  logic [ca_pkg::RULE_BITS-1:0] rule,
   output logic [ROW_WIDTH-1:0]         next_row
);

   // Cell 0 is the leftmost pixel, so the left neighbour is i-1
   for (genvar i = 0; i < ROW_WIDTH; i++)
   begin : g_cell
      logic left;
      logic right;

      if (i == 0)
      begin : g_left_edge
         assign left = 1'b0;                 // Zero padding
      end
      else
      begin : g_left_cell
         assign left = cur_row[i-1];
      end

      if (i == ROW_WIDTH - 1)
      begin : g_right_edge
         assign right = 1'b0;                // Zero padding
      end
      else
      begin : g_right_cell
         assign right = cur_row[i+1];
      end

      // Neighbourhood value 4*left + 2*centre + right picks the rule bit
      assign next_row[i] = rule[{left, cur_row[i], right}];
   end

endmodule

//--- verilog/ca_pkg.sv
//////////////////////////////////////////////////////////////////////
// Cellular automaton shared definitions
// Controller states, rule width and the power-up contents of the
// random row LFSR bank
//////////////////////////////////////////////////////////////////////

package ca_pkg;

   // Eight neighbourhoods, one rule bit each
   localparam int RULE_BITS = 8;

   // One LFSR word covers 32 cells
   localparam int LFSR_BITS = 32;
   localparam int MAX_WORDS = 20;            // 640 cells max

   //////////////////////////////////////////////////////////////////
   // LFSR reset values, element k feeds cells 32k up to 32k+31
   //////////////////////////////////////////////////////////////////
   localparam logic [LFSR_BITS-1:0] LFSR_SEEDS [MAX_WORDS] = '{
      32'h7820_6410,                         // Cells 0..31
      32'h4c4e_2afb,
      32'h080c_1254,
      32'h3dea_4fc9,
      32'h520b_3de8,
      32'hda62_26b3,
      32'h5a21_3cb2,
      32'he3bf_4f0c,
      32'h0c22_d55a,
      32'h7184_b67f,
      32'ha15f_a105,
      32'h1fa4_6164,
      32'h73b1_adbf,
      32'h273c_0dae,
      32'h8b9d_ec83,
      32'h15f2_b949,
      32'h7a07_037e,
      32'h1f64_ff19,
      32'ha8c3_0101,
      32'hf923_2a25                          // Cells 608..639
   };

   // Raster controller states
   typedef enum logic [2:0] {
      LOAD,                                  // Seed the current row
      SET_PIXEL,                             // Address settles
      WRITE_PIXEL,                           // Write strobe
      ADVANCE,                               // Next column or row end
      NEXT_ROW,                              // Row update cycle
      IDLE,                                  // Frame done, wait for press
      HOLD                                   // Wait for release
   } ca_state_e;

endpackage

//--- verilog/ca_row_store.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Current row storage
// Samples the rule and seed mode in reset, seeds the row at frame
// start, steps it to the next generation at each row end and picks
// the bit of the column being written
//////////////////////////////////////////////////////////////////////

module ca_row_store #(
   parameter int ROW_WIDTH = 640
) (
   input  logic                         SW,
   input  logic                         reset,
   input  logic [ca_pkg::RULE_BITS-1:0] rule_sel,
   input  logic                         random_seed,
   input  logic                         seed_load,
   input  logic                         row_step,
   input  logic [$clog2(ROW_WIDTH)-1:0] col,
   input  logic [ROW_WIDTH-1:0]         random_row,
   input  logic [ROW_WIDTH-1:0]         next_row,
   output logic [ROW_WIDTH-1:0]         cur_row,
   output logic [ca_pkg::RULE_BITS-1:0] rule,
   output logic                         pix_bit
);

   // Single live cell in the middle
   localparam logic [ROW_WIDTH-1:0] DOT_SEED = ROW_WIDTH'(1) << (ROW_WIDTH / 2);

   logic random_mode;                        // Seed mode latched in reset
   logic first_load;                         // No seed taken since reset

   //////////////////////////////////////////////////////////////////
   // Mode and rule capture
   //////////////////////////////////////////////////////////////////
   always_ff @(posedge SW)
   begin
      if (reset)
      begin
         rule        <= rule_sel;            // Follows the switches in reset
         random_mode <= random_seed;
         first_load  <= 1'b1;
      end
      else if (seed_load)
      begin
         first_load <= 1'b0;
      end
   end

   //////////////////////////////////////////////////////////////////
   // Row register
   //////////////////////////////////////////////////////////////////
   always_ff @(posedge SW)
   begin
      if (seed_load)
      begin
         // Dot mode only seeds once, later frames keep evolving
         if (random_mode)
            cur_row <= random_row;
         else if (first_load)
            cur_row <= DOT_SEED;
      end
      else if (row_step)
      begin
         cur_row <= next_row;                // Next generation
      end
   end

   // Pixel x shows cell x
   assign pix_bit = cur_row[col];

endmodule

//--- verilog/ca_scan_ctrl.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Raster controller
// Walks every pixel of the frame in x then y order, strobes one
// write per pixel and steps the row store at each row end. After
// the last row it waits for a restart press and release
//////////////////////////////////////////////////////////////////////

module ca_scan_ctrl #(
   parameter int ROW_WIDTH = 640,
   parameter int ROW_COUNT = 480
) (
   input  logic                         SW,
   input  logic                         reset,
   input  logic                         restart,
   output logic [$clog2(ROW_WIDTH)-1:0] col,
   output logic [$clog2(ROW_COUNT)-1:0] row,
   output logic                         pix_we,
   output logic                         seed_load,
   output logic                         seed_step,
   output logic                         row_step,
   output logic                         frame_done
);

   localparam int COL_BITS = $clog2(ROW_WIDTH);
   localparam int ROW_BITS = $clog2(ROW_COUNT);

   localparam logic [COL_BITS-1:0] COL_LAST = COL_BITS'(ROW_WIDTH - 1);
   localparam logic [ROW_BITS-1:0] ROW_LAST = ROW_BITS'(ROW_COUNT - 1);

   ca_pkg::ca_state_e state;
   logic              restart_q;             // Previous restart level
   logic              last_col;
   logic              last_row;

   assign last_col = (col == COL_LAST);
   assign last_row = (row == ROW_LAST);

   //////////////////////////////////////////////////////////////////
   // State machine, all strobes registered
   //////////////////////////////////////////////////////////////////
   always_ff @(posedge SW)
   begin
      if (reset)
      begin
         state      <= ca_pkg::LOAD;
         col        <= '0;
         row        <= '0;
         pix_we     <= 1'b0;
         seed_load  <= 1'b0;
         seed_step  <= 1'b0;
         row_step   <= 1'b0;
         frame_done <= 1'b0;
         restart_q  <= 1'b0;
      end
      else
      begin
         restart_q <= restart;
         pix_we    <= 1'b0;                  // Strobes last one cycle
         seed_load <= 1'b0;
         seed_step <= 1'b0;
         row_step  <= 1'b0;

         case (state)
            ca_pkg::LOAD:
            begin
               seed_load  <= 1'b1;           // Row valid from WRITE_PIXEL on
               frame_done <= 1'b0;           // New frame starts
               col        <= '0;
               row        <= '0;
               state      <= ca_pkg::SET_PIXEL;
            end

            ca_pkg::SET_PIXEL:
            begin
               pix_we <= 1'b1;               // Address and bit now stable
               state  <= ca_pkg::WRITE_PIXEL;
            end

            ca_pkg::WRITE_PIXEL:
            begin
               // Done flag rises right after the final write
               if (last_col && last_row)
                  frame_done <= 1'b1;
               state <= ca_pkg::ADVANCE;
            end

            ca_pkg::ADVANCE:
            begin
               if (last_col)
               begin
                  col      <= '0;
                  row_step <= 1'b1;          // Also on the last row, for dot restart
                  if (last_row)
                  begin
                     state <= ca_pkg::IDLE;
                  end
                  else
                  begin
                     row   <= row + 1'b1;
                     state <= ca_pkg::NEXT_ROW;
                  end
               end
               else
               begin
                  col   <= col + 1'b1;
                  state <= ca_pkg::SET_PIXEL;
               end
            end

            ca_pkg::NEXT_ROW:
            begin
               state <= ca_pkg::SET_PIXEL;   // Row store updates here
            end

            ca_pkg::IDLE:
            begin
               // Press edge only, a held button does not count
               if (restart && !restart_q)
                  state <= ca_pkg::HOLD;
            end

            ca_pkg::HOLD:
            begin
               if (!restart)
               begin
                  seed_step <= 1'b1;         // One LFSR step per restart
                  state     <= ca_pkg::LOAD;
               end
            end

            default:
            begin
               state <= ca_pkg::IDLE;
            end
         endcase
      end
   end

endmodule

//--- verilog/ca_seed_lfsr.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Random row source
// A bank of 32-bit Fibonacci LFSRs, one per 32 cells of the row.
// All words load their table value in reset and step together
// once per seed_step strobe
//////////////////////////////////////////////////////////////////////

module ca_seed_lfsr #(
   parameter int ROW_WIDTH = 640
) (
   input  logic                 SW,
   input  logic                 reset,
   input  logic                 seed_step,
   output logic [ROW_WIDTH-1:0] random_row
);

   localparam int WORDS = ROW_WIDTH / ca_pkg::LFSR_BITS;

   for (genvar k = 0; k < WORDS; k++)
   begin : g_word
      logic [ca_pkg::LFSR_BITS-1:0] word;
      logic                         feedback;

      // Taps 31, 21, 1 and 0
      assign feedback = word[ca_pkg::LFSR_BITS-1] ^ word[21] ^ word[1] ^ word[0];

      always_ff @(posedge SW)
      begin
         if (reset)
         begin
            word <= ca_pkg::LFSR_SEEDS[k];   // Known start per word
         end
         else if (seed_step)
         begin
            word <= {word[ca_pkg::LFSR_BITS-2:0], feedback}; // Shift left
         end
      end

      // Word k drives cells 32k and up
      assign random_row[k*ca_pkg::LFSR_BITS +: ca_pkg::LFSR_BITS] = word;
   end

endmodule
